/* common/grn_config.svh */
`ifndef GRN_CONFIG_SVH
`define GRN_CONFIG_SVH

// network size, every state vector is this wide
`define GRN_NODES 16

// input FIFO holds 8 tasks, output FIFO holds 16 results
`define GRN_IN_DEPTH_BITS 3
`define GRN_OUT_DEPTH_BITS 4

// host must stop sending once the input FIFO reaches this occupancy
`define GRN_IN_AFULL 6

// has_lst3_data_out is high at or below this many stored results
`define GRN_OUT_AEMPTY 2

// the search gives up after this many iterations
`define GRN_MAX_STEPS 200

`endif

/* common/grn_state_pkg.sv */
`include "grn_config.svh"

package grn_state_pkg;

  // one full network state, bit i is the value of gene i
  typedef logic [`GRN_NODES-1:0] node_vec_t;

  // iteration count of one search, wide enough for GRN_MAX_STEPS
  typedef logic [7:0] step_cnt_t;

endpackage

/* common/grn_stream_pkg.sv */
`include "grn_config.svh"

package grn_stream_pkg;

  typedef logic [7:0] task_tag_t;
  typedef logic [7:0] task_seq_t;

  // word stored in the input FIFO, one per task
  typedef struct packed {
    task_tag_t                tag;
    task_seq_t                seq;
    grn_state_pkg::node_vec_t init;
  } task_word_t;

  // word stored in the output FIFO, one per finished search
  typedef struct packed {
    task_tag_t                tag;
    task_seq_t                seq;
    logic                     limit_hit;
    grn_state_pkg::step_cnt_t steps;
    grn_state_pkg::node_vec_t meet;
  } result_word_t;

endpackage

/* design/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH      = 32,
  parameter int DEPTH_BITS = 3,
  parameter int AFULL_TH   = 6,
  parameter int AEMPTY_TH  = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  logic [WIDTH-1:0] din,
  input  logic             re,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             almost_empty,
  output logic             full,
  output logic             almost_full
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   mem_cnt;
  logic [DEPTH_BITS:0]   count;
  logic                  head_valid;
  logic                  push;
  logic                  pop;
  logic                  prefetch;

  assign push = we && !full;
  assign pop = re && head_valid;

  // the head register refills from the array whenever it is free or being popped
  assign prefetch = (mem_cnt != '0) && (!head_valid || pop);

  // count covers the array and the head register, it never exceeds DEPTH
  assign empty = !head_valid;
  assign full = count[DEPTH_BITS];
  assign almost_full = (count >= AFULL_TH);
  assign almost_empty = (count <= AEMPTY_TH);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
    if (prefetch) begin
      dout <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      mem_cnt <= '0;
      count <= '0;
      head_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (prefetch) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, prefetch})
        2'b10:   mem_cnt <= mem_cnt + 1'b1;
        2'b01:   mem_cnt <= mem_cnt - 1'b1;
        default: mem_cnt <= mem_cnt;
      endcase
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (prefetch) begin
        head_valid <= 1'b1;
      end else if (pop) begin
        head_valid <= 1'b0;
      end
    end
  end

endmodule

/* design/input_packer.sv */
`timescale 1ns/1ps

module input_packer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic                       data_in_valid,
  input  logic [23:0]                data_in,
  output logic                       fifo_in_we,
  output grn_stream_pkg::task_word_t fifo_in_data
);

  import grn_stream_pkg::*;

  task_seq_t seq_cnt;
  task_seq_t cur_seq;

  // a start pulse restarts numbering even for a task in the same cycle
  assign cur_seq = start ? '0 : seq_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      fifo_in_we <= 1'b0;
      seq_cnt <= '0;
    end else begin
      fifo_in_we <= data_in_valid;
      seq_cnt <= data_in_valid ? cur_seq + 1'b1 : cur_seq;
    end
  end

  // host word layout is tag in the upper byte, initial state below it
  always_ff @(posedge clk) begin
    if (data_in_valid) begin
      fifo_in_data.tag <= task_tag_t'(data_in[23:16]);
      fifo_in_data.seq <= cur_seq;
      fifo_in_data.init <= data_in[15:0];
    end
  end

endmodule

/* network_graph/network_graph.sv */
`timescale 1ns/1ps
`include "grn_config.svh"

module network_graph (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     load,
  input  logic                     step,
  input  grn_state_pkg::node_vec_t init,
  output grn_state_pkg::node_vec_t s0,
  output grn_state_pkg::node_vec_t s1
);

  import grn_state_pkg::*;

  node_vec_t s0_next;
  node_vec_t s1_half;
  node_vec_t s1_next;

  // ======================================================================
  // update rule, all gene indices wrap around the ring
  // ======================================================================

  function automatic node_vec_t grn_update(input node_vec_t x);
    node_vec_t nxt;
    for (int i = 0; i < `GRN_NODES; i++) begin
      nxt[i] = (x[(i + `GRN_NODES - 1) % `GRN_NODES] ^ x[(i + 3) % `GRN_NODES])
             | (x[(i + 1) % `GRN_NODES] & ~x[(i + 5) % `GRN_NODES]);
    end
    return nxt;
  endfunction

  // slow copy moves one step, fast copy chains two rule evaluations
  assign s0_next = grn_update(s0);
  assign s1_half = grn_update(s1);
  assign s1_next = grn_update(s1_half);

  // ======================================================================
  // state registers
  // ======================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      s0 <= '0;
      s1 <= '0;
    end else if (load) begin
      s0 <= init;
      s1 <= init;
    end else if (step) begin
      s0 <= s0_next;
      s1 <= s1_next;
    end
  end

endmodule

/* network_graph/attractor_ctrl.sv */
`timescale 1ns/1ps
`include "grn_config.svh"

module attractor_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  input  logic                         end_data_in,
  input  logic                         fifo_in_empty,
  input  grn_stream_pkg::task_word_t   fifo_in_data,
  output logic                         fifo_in_re,
  input  grn_state_pkg::node_vec_t     s0,
  input  grn_state_pkg::node_vec_t     s1,
  output logic                         load,
  output logic                         step,
  output grn_state_pkg::node_vec_t     init,
  input  logic                         fifo_out_full,
  output logic                         fifo_out_we,
  output grn_stream_pkg::result_word_t fifo_out_data,
  output logic                         done
);

  import grn_state_pkg::*;
  import grn_stream_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    RUN,
    WRITE,
    FINISH
  } ctrl_state_t;

  ctrl_state_t state;
  task_tag_t   cur_tag;
  task_seq_t   cur_seq;
  step_cnt_t   step_cnt;
  logic        limit_hit;
  logic [1:0]  end_dly;
  logic        end_seen;
  logic        met;
  logic        at_limit;

  // both copies start equal, so a match only counts after the first step
  assign met = (step_cnt != '0) && (s0 == s1);
  assign at_limit = (step_cnt == step_cnt_t'(`GRN_MAX_STEPS));

  assign load = (state == LOAD);
  assign fifo_in_re = (state == LOAD);
  assign step = (state == RUN) && !met && !at_limit;
  assign fifo_out_we = (state == WRITE) && !fifo_out_full;
  assign done = (state == FINISH);
  assign init = fifo_in_data.init;

  // s0 is frozen once stepping stops, so it is the meeting state
  assign fifo_out_data.tag = cur_tag;
  assign fifo_out_data.seq = cur_seq;
  assign fifo_out_data.limit_hit = limit_hit;
  assign fifo_out_data.steps = step_cnt;
  assign fifo_out_data.meet = s0;

  // ======================================================================
  // control FSM
  // ======================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      step_cnt <= '0;
      limit_hit <= 1'b0;
      end_dly <= '0;
      end_seen <= 1'b0;
    end else begin
      // end marker is delayed past the packer and FIFO prefetch so a late
      // task is already visible at the head before the drain check
      end_dly <= {end_dly[0], end_data_in};
      if (end_dly[1]) begin
        end_seen <= 1'b1;
      end else if (start) begin
        end_seen <= 1'b0;
      end

      case (state)
        IDLE: begin
          if (!fifo_in_empty) begin
            state <= LOAD;
          end else if (end_seen) begin
            state <= FINISH;
          end
        end
        LOAD: begin
          step_cnt <= '0;
          limit_hit <= 1'b0;
          state <= RUN;
        end
        RUN: begin
          if (met) begin
            state <= WRITE;
          end else if (at_limit) begin
            limit_hit <= 1'b1;
            state <= WRITE;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        WRITE: begin
          if (!fifo_out_full) begin
            state <= IDLE;
          end
        end
        FINISH: begin
          if (start) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == LOAD) begin
      cur_tag <= fifo_in_data.tag;
      cur_seq <= fifo_in_data.seq;
    end
  end

endmodule

/* design/regulator_network.sv */
`timescale 1ns/1ps
`include "grn_config.svh"

module regulator_network (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  input  logic                         data_in_valid,
  input  logic [23:0]                  data_in,
  input  logic                         end_data_in,
  input  logic                         read_data_en,
  output logic                         in_almost_full,
  output logic                         has_data_out,
  output logic                         has_lst3_data_out,
  output grn_stream_pkg::result_word_t data_out,
  output logic                         task_done
);

  import grn_state_pkg::*;
  import grn_stream_pkg::*;

  task_word_t   fifo_in_data;
  task_word_t   fifo_in_head;
  result_word_t fifo_out_data;
  node_vec_t    s0;
  node_vec_t    s1;
  node_vec_t    init;
  logic         fifo_in_we;
  logic         fifo_in_re;
  logic         fifo_in_empty;
  logic         fifo_out_we;
  logic         fifo_out_empty;
  logic         fifo_out_full;
  logic         load;
  logic         step;

  assign has_data_out = !fifo_out_empty;

  // ======================================================================
  // task input path
  // ======================================================================

  input_packer i_input_packer (
    .clk(clk),
    .rst(rst),
    .start(start),
    .data_in_valid(data_in_valid),
    .data_in(data_in),
    .fifo_in_we(fifo_in_we),
    .fifo_in_data(fifo_in_data)
  );

  sync_fifo #(
    .WIDTH($bits(task_word_t)),
    .DEPTH_BITS(`GRN_IN_DEPTH_BITS),
    .AFULL_TH(`GRN_IN_AFULL),
    .AEMPTY_TH(1)
  ) fifo_in (
    .clk(clk),
    .rst(rst),
    .we(fifo_in_we),
    .din(fifo_in_data),
    .re(fifo_in_re),
    .dout(fifo_in_head),
    .empty(fifo_in_empty),
    .almost_empty(),
    .full(),
    .almost_full(in_almost_full)
  );

  // ======================================================================
  // search engine
  // ======================================================================

  attractor_ctrl i_attractor_ctrl (
    .clk(clk),
    .rst(rst),
    .start(start),
    .end_data_in(end_data_in),
    .fifo_in_empty(fifo_in_empty),
    .fifo_in_data(fifo_in_head),
    .fifo_in_re(fifo_in_re),
    .s0(s0),
    .s1(s1),
    .load(load),
    .step(step),
    .init(init),
    .fifo_out_full(fifo_out_full),
    .fifo_out_we(fifo_out_we),
    .fifo_out_data(fifo_out_data),
    .done(task_done)
  );

  network_graph i_network_graph (
    .clk(clk),
    .rst(rst),
    .load(load),
    .step(step),
    .init(init),
    .s0(s0),
    .s1(s1)
  );

  // results wait here until the host pops them
  sync_fifo #(
    .WIDTH($bits(result_word_t)),
    .DEPTH_BITS(`GRN_OUT_DEPTH_BITS),
    .AFULL_TH((1 << `GRN_OUT_DEPTH_BITS) - 2),
    .AEMPTY_TH(`GRN_OUT_AEMPTY)
  ) fifo_out (
    .clk(clk),
    .rst(rst),
    .we(fifo_out_we),
    .din(fifo_out_data),
    .re(read_data_en),
    .dout(data_out),
    .empty(fifo_out_empty),
    .almost_empty(has_lst3_data_out),
    .full(fifo_out_full),
    .almost_full()
  );

endmodule

/* test/tb_regulator_network.sv */
`timescale 1ns/1ps
`include "grn_config.svh"

module tb_regulator_network;

  import grn_state_pkg::*;
  import grn_stream_pkg::*;

  localparam int TABLE_LEN = 24;
  localparam int RUN_A_LEN = 20;
  localparam int OUT_DEPTH = 1 << `GRN_OUT_DEPTH_BITS;
  localparam int CYCLE_LIMIT = TABLE_LEN * (`GRN_MAX_STEPS + 10) + 200;
  localparam int SCAN_TRIES = 512;

  logic         clk;
  logic         rst;
  logic         start;
  logic         data_in_valid;
  logic [23:0]  data_in;
  logic         end_data_in;
  logic         read_data_en;
  logic         in_almost_full;
  logic         has_data_out;
  logic         has_lst3_data_out;
  result_word_t data_out;
  logic         task_done;

  // stimulus and expected results with one row per task
  task_tag_t tag_tab [TABLE_LEN];
  node_vec_t init_tab [TABLE_LEN];
  int        stall_tab [TABLE_LEN];
  node_vec_t exp_meet [TABLE_LEN];
  step_cnt_t exp_steps [TABLE_LEN];
  logic      exp_limit [TABLE_LEN];

  int   cycle_cnt;
  int   unread_cnt;
  int   queued_cnt;
  logic valid_dly;

  regulator_network i_dut (
    .clk(clk),
    .rst(rst),
    .start(start),
    .data_in_valid(data_in_valid),
    .data_in(data_in),
    .end_data_in(end_data_in),
    .read_data_en(read_data_en),
    .in_almost_full(in_almost_full),
    .has_data_out(has_data_out),
    .has_lst3_data_out(has_lst3_data_out),
    .data_out(data_out),
    .task_done(task_done)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ======================================================================
  // reference model
  // ======================================================================

  // bit i of the result holds x[i+k] with the index wrapping around
  function automatic node_vec_t rotate_down(input node_vec_t x, input int k);
    return (x >> k) | (x << (`GRN_NODES - k));
  endfunction

  function automatic node_vec_t next_state(input node_vec_t x);
    return (rotate_down(x, `GRN_NODES - 1) ^ rotate_down(x, 3))
         | (rotate_down(x, 1) & ~rotate_down(x, 5));
  endfunction

  task automatic floyd_search(input node_vec_t init, output node_vec_t meet,
                              output int steps, output logic limit);
    node_vec_t slow;
    node_vec_t fast;
    logic      searching;
    slow = init;
    fast = init;
    steps = 0;
    limit = 1'b0;
    searching = 1'b1;
    while (searching) begin
      if (steps == `GRN_MAX_STEPS) begin
        limit = 1'b1;
        searching = 1'b0;
      end else begin
        slow = next_state(slow);
        fast = next_state(next_state(fast));
        steps++;
        if (slow == fast) begin
          searching = 1'b0;
        end
      end
    end
    meet = slow;
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic build_table();
    node_vec_t cand;
    node_vec_t meet;
    node_vec_t longest;
    int        steps;
    int        longest_steps;
    logic      limit;
    longest = '0;
    longest_steps = -1;
    // pick the slowest of a batch of random states as the long search
    for (int n = 0; n < SCAN_TRIES; n++) begin
      cand = node_vec_t'($urandom());
      floyd_search(cand, meet, steps, limit);
      if (steps > longest_steps) begin
        longest = cand;
        longest_steps = steps;
      end
    end
    for (int i = 0; i < TABLE_LEN; i++) begin
      tag_tab[i] = task_tag_t'($urandom());
      init_tab[i] = node_vec_t'($urandom());
      stall_tab[i] = $urandom() % 4;
    end
    init_tab[0] = '0;
    init_tab[1] = '1;
    init_tab[2] = longest;
    init_tab[RUN_A_LEN] = '1;
    for (int i = 0; i < TABLE_LEN; i++) begin
      floyd_search(init_tab[i], meet, steps, limit);
      exp_meet[i] = meet;
      exp_steps[i] = step_cnt_t'(steps);
      exp_limit[i] = limit;
    end
    $display("longest search in table: %0d steps", longest_steps);
  endtask

  // ======================================================================
  // host side tasks
  // ======================================================================

  task automatic pulse_start();
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
  endtask

  task automatic pulse_end();
    end_data_in <= 1'b1;
    @(posedge clk);
    end_data_in <= 1'b0;
    @(posedge clk);
  endtask

  // one idle cycle after each task keeps at most one word in flight
  task automatic submit_task(input int idx);
    while (in_almost_full) begin
      @(posedge clk);
    end
    data_in <= {tag_tab[idx], init_tab[idx]};
    data_in_valid <= 1'b1;
    @(posedge clk);
    data_in_valid <= 1'b0;
    @(posedge clk);
  endtask

  task automatic read_result(input int idx, input int seq_exp);
    while (!has_data_out) begin
      @(posedge clk);
    end
    check_value("data_out.tag", data_out.tag, tag_tab[idx]);
    check_value("data_out.seq", data_out.seq, task_seq_t'(seq_exp));
    check_value("data_out.meet", data_out.meet, exp_meet[idx]);
    check_value("data_out.steps", data_out.steps, exp_steps[idx]);
    check_value("data_out.limit_hit", data_out.limit_hit, exp_limit[idx]);
    read_data_en <= 1'b1;
    @(posedge clk);
    read_data_en <= 1'b0;
    // the popped word is gone from the head only after this edge
    @(posedge clk);
    repeat (stall_tab[idx]) @(posedge clk);
  endtask

  // ======================================================================
  // monitors
  // ======================================================================

  // count of unread results in the output FIFO as seen from its write and read strobes
  always @(posedge clk) begin
    if (rst) begin
      unread_cnt <= 0;
    end else begin
      check_value("has_lst3_data_out", has_lst3_data_out,
                  (unread_cnt <= `GRN_OUT_AEMPTY) ? 1'b1 : 1'b0);
      unread_cnt <= unread_cnt + (i_dut.fifo_out_we ? 1 : 0)
                  - ((read_data_en && has_data_out) ? 1 : 0);
    end
  end

  // tasks held in the input FIFO where a write lands one cycle after data_in_valid
  always @(posedge clk) begin
    if (rst) begin
      valid_dly <= 1'b0;
      queued_cnt <= 0;
    end else begin
      check_value("in_almost_full", in_almost_full,
                  (queued_cnt >= `GRN_IN_AFULL) ? 1'b1 : 1'b0);
      valid_dly <= data_in_valid;
      queued_cnt <= queued_cnt + (valid_dly ? 1 : 0) - (i_dut.fifo_in_re ? 1 : 0);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the DUT did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("tests failed");
      $fatal(1, "simulation stopped by cycle limit");
    end
  end

  // ======================================================================
  // main sequence
  // ======================================================================

  initial begin
    rst = 1'b1;
    start = 1'b0;
    data_in_valid = 1'b0;
    data_in = '0;
    end_data_in = 1'b0;
    read_data_en = 1'b0;
    cycle_cnt = 0;
    void'($urandom(67100));
    build_table();

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("task_done", task_done, 1'b0);

    // first run overfills the output FIFO before anything is read
    pulse_start();
    for (int i = 0; i < RUN_A_LEN; i++) begin
      submit_task(i);
    end
    pulse_end();
    while (unread_cnt < OUT_DEPTH) begin
      @(posedge clk);
    end
    check_value("task_done", task_done, 1'b0);
    for (int i = 0; i < RUN_A_LEN; i++) begin
      read_result(i, i);
    end
    while (!task_done) begin
      @(posedge clk);
    end
    check_value("unread_cnt", unread_cnt, 0);

    // second run numbers its tasks from zero again
    pulse_start();
    check_value("task_done", task_done, 1'b0);
    for (int i = RUN_A_LEN; i < TABLE_LEN; i++) begin
      submit_task(i);
    end
    pulse_end();
    for (int i = RUN_A_LEN; i < TABLE_LEN; i++) begin
      read_result(i, i - RUN_A_LEN);
    end
    while (!task_done) begin
      @(posedge clk);
    end
    check_value("unread_cnt", unread_cnt, 0);

    $display("all tests passed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+common
common/grn_state_pkg.sv
common/grn_stream_pkg.sv
design/sync_fifo.sv
design/input_packer.sv
network_graph/network_graph.sv
network_graph/attractor_ctrl.sv
design/regulator_network.sv
test/tb_regulator_network.sv
